// ==== logic/ex_stage.sv ====
// Execute stage: 64-bit ALU, forwarding tap and execute-to-writeback register
`timescale 1ns/1ps

module ex_stage (
    input  logic           clk,
    input  logic           reset_i,
    input  rv_pkg::id_ex_t idex_i,
    output rv_pkg::fwd_t   ex_fwd_o,
    output rv_pkg::ex_wb_t exwb_o
);

    logic [rv_pkg::XLEN-1:0] alu_res;
    logic [5:0]              shamt;
    rv_pkg::ex_wb_t          exwb_q;

    assign shamt = idex_i.op_b[5:0];  // rv64 shift amount

    always_comb begin
        case (idex_i.alu_op)
            rv_pkg::ALU_ADD:    alu_res = idex_i.op_a + idex_i.op_b;
            rv_pkg::ALU_SUB:    alu_res = idex_i.op_a - idex_i.op_b;
            rv_pkg::ALU_AND:    alu_res = idex_i.op_a & idex_i.op_b;
            rv_pkg::ALU_OR:     alu_res = idex_i.op_a | idex_i.op_b;
            rv_pkg::ALU_XOR:    alu_res = idex_i.op_a ^ idex_i.op_b;
            rv_pkg::ALU_SLL:    alu_res = idex_i.op_a << shamt;
            rv_pkg::ALU_SRL:    alu_res = idex_i.op_a >> shamt;  // logical
            rv_pkg::ALU_PASS_B: alu_res = idex_i.op_b;
            default:            alu_res = '0;
        endcase
    end

    // result goes straight back to decode in the same cycle
    always_comb begin
        ex_fwd_o.valid = idex_i.valid & idex_i.reg_wen;
        ex_fwd_o.rd    = idex_i.rd;
        ex_fwd_o.data  = alu_res;
    end

    always_ff @(posedge clk) begin
        exwb_q.pc      <= idex_i.pc;
        exwb_q.rd      <= idex_i.rd;
        exwb_q.reg_wen <= idex_i.reg_wen;
        exwb_q.result  <= alu_res;
        exwb_q.ebreak  <= idex_i.ebreak;
        exwb_q.valid   <= idex_i.valid;
        if (reset_i) begin
            exwb_q.valid <= 1'b0;
        end
    end

    assign exwb_o = exwb_q;

endmodule

// ==== logic/id_stage.sv ====
// Decode stage: instruction decode, operand forwarding, branch resolution and decode-to-execute register
`timescale 1ns/1ps

module id_stage (
    input  logic                    clk,
    input  logic                    reset_i,
    input  rv_pkg::fetch_t          fetch_i,
    output logic [rv_pkg::RA_W-1:0] rs1_addr_o,
    output logic [rv_pkg::RA_W-1:0] rs2_addr_o,
    input  logic [rv_pkg::XLEN-1:0] rs1_data_i,
    input  logic [rv_pkg::XLEN-1:0] rs2_data_i,
    input  rv_pkg::fwd_t            ex_fwd_i,
    input  rv_pkg::fwd_t            wb_fwd_i,
    output logic                    redirect_o,
    output logic [rv_pkg::XLEN-1:0] target_o,
    output logic                    stop_fetch_o,
    output rv_pkg::id_ex_t          idex_o
);

    rv_pkg::inst_u           inst;
    rv_pkg::alu_op_e         alu_op;
    logic [rv_pkg::XLEN-1:0] imm;
    logic [rv_pkg::XLEN-1:0] b_off;
    logic [rv_pkg::XLEN-1:0] rs1_val;
    logic [rv_pkg::XLEN-1:0] rs2_val;
    logic                    dec_ok;
    logic                    uses_rs1;
    logic                    b_is_imm;
    logic                    wen;
    logic                    is_beq;
    logic                    is_bne;
    logic                    is_ebreak;
    logic                    taken;
    logic                    stop_q;
    rv_pkg::id_ex_t          idex_d;
    rv_pkg::id_ex_t          idex_q;

    // execute result wins over writeback, writeback over the register file
    function automatic logic [rv_pkg::XLEN-1:0] pick_operand(
        input logic [rv_pkg::RA_W-1:0] addr,
        input logic [rv_pkg::XLEN-1:0] rf_data,
        input rv_pkg::fwd_t            ex_src,
        input rv_pkg::fwd_t            wb_src
    );
        if (addr != '0 && ex_src.valid && ex_src.rd == addr) begin
            return ex_src.data;
        end else if (addr != '0 && wb_src.valid && wb_src.rd == addr) begin
            return wb_src.data;
        end
        return rf_data;
    endfunction

    assign inst       = fetch_i.inst;
    assign rs1_addr_o = inst.r.rs1;
    assign rs2_addr_o = inst.r.rs2;
    assign rs1_val    = pick_operand(inst.r.rs1, rs1_data_i, ex_fwd_i, wb_fwd_i);
    assign rs2_val    = pick_operand(inst.r.rs2, rs2_data_i, ex_fwd_i, wb_fwd_i);

    always_comb begin
        dec_ok    = 1'b0;
        alu_op    = rv_pkg::ALU_ADD;
        uses_rs1  = 1'b1;
        b_is_imm  = 1'b0;
        imm       = '0;
        wen       = 1'b0;
        is_beq    = 1'b0;
        is_bne    = 1'b0;
        is_ebreak = 1'b0;
        case (inst.r.opcode)
            rv_pkg::OPC_OP: begin
                dec_ok = 1'b1;
                wen    = 1'b1;
                case ({inst.r.funct7, inst.r.funct3})
                    10'b0000000_000: alu_op = rv_pkg::ALU_ADD;
                    10'b0100000_000: alu_op = rv_pkg::ALU_SUB;
                    10'b0000000_111: alu_op = rv_pkg::ALU_AND;
                    10'b0000000_110: alu_op = rv_pkg::ALU_OR;
                    10'b0000000_100: alu_op = rv_pkg::ALU_XOR;
                    10'b0000000_001: alu_op = rv_pkg::ALU_SLL;
                    10'b0000000_101: alu_op = rv_pkg::ALU_SRL;
                    default:         dec_ok = 1'b0;
                endcase
            end
            rv_pkg::OPC_OP_IMM: begin
                dec_ok   = 1'b1;
                wen      = 1'b1;
                b_is_imm = 1'b1;
                imm      = {{(rv_pkg::XLEN-12){inst.i.imm[11]}}, inst.i.imm};
                case (inst.i.funct3)
                    3'b000: alu_op = rv_pkg::ALU_ADD;
                    3'b111: alu_op = rv_pkg::ALU_AND;
                    3'b110: alu_op = rv_pkg::ALU_OR;
                    3'b100: alu_op = rv_pkg::ALU_XOR;
                    3'b001: begin
                        alu_op = rv_pkg::ALU_SLL;
                        dec_ok = (inst.i.imm[11:6] == 6'b0);  // funct6 must be zero
                    end
                    3'b101: begin
                        alu_op = rv_pkg::ALU_SRL;
                        dec_ok = (inst.i.imm[11:6] == 6'b0);  // srai not supported
                    end
                    default: dec_ok = 1'b0;
                endcase
            end
            rv_pkg::OPC_LUI: begin
                dec_ok   = 1'b1;
                wen      = 1'b1;
                uses_rs1 = 1'b0;
                b_is_imm = 1'b1;
                alu_op   = rv_pkg::ALU_PASS_B;
                imm      = {{(rv_pkg::XLEN-32){inst.u.imm[19]}}, inst.u.imm, 12'b0};
            end
            rv_pkg::OPC_BRANCH: begin
                uses_rs1 = 1'b0;  // retires with zero data
                b_is_imm = 1'b1;
                is_beq   = (inst.r.funct3 == 3'b000);
                is_bne   = (inst.r.funct3 == 3'b001);
                dec_ok   = is_beq | is_bne;
            end
            rv_pkg::OPC_SYSTEM: begin
                uses_rs1  = 1'b0;
                b_is_imm  = 1'b1;
                is_ebreak = (inst == rv_pkg::EBREAK_WORD);
                dec_ok    = is_ebreak;
            end
            default: dec_ok = 1'b0;  // unsupported, becomes a bubble
        endcase
    end

    // branches resolve here, one bubble when taken
    assign b_off = {{(rv_pkg::XLEN-13){inst.b.imm_12}}, inst.b.imm_12, inst.b.imm_11,
                    inst.b.imm_10_5, inst.b.imm_4_1, 1'b0};
    assign taken = (is_beq && rs1_val == rs2_val) || (is_bne && rs1_val != rs2_val);
    assign redirect_o   = fetch_i.valid & taken;
    assign target_o     = fetch_i.pc + b_off;
    assign stop_fetch_o = stop_q | (fetch_i.valid & is_ebreak);

    always_ff @(posedge clk) begin
        if (reset_i) begin
            stop_q <= 1'b0;
        end else if (fetch_i.valid && is_ebreak) begin
            stop_q <= 1'b1;  // held until reset
        end
    end

    always_comb begin
        idex_d.valid   = fetch_i.valid & dec_ok;
        idex_d.pc      = fetch_i.pc;
        idex_d.alu_op  = alu_op;
        idex_d.op_a    = uses_rs1 ? rs1_val : '0;
        idex_d.op_b    = b_is_imm ? imm : rs2_val;
        idex_d.rd      = wen ? inst.r.rd : '0;  // no destination for branch and ebreak
        idex_d.reg_wen = wen;
        idex_d.ebreak  = is_ebreak;
    end

    always_ff @(posedge clk) begin
        idex_q <= idex_d;
        if (reset_i) begin
            idex_q.valid <= 1'b0;
        end
    end

    assign idex_o = idex_q;

endmodule

// ==== logic/if_stage.sv ====
// Fetch stage: program counter, instruction port, redirect and stop, fetch-to-decode register
`timescale 1ns/1ps

module if_stage (
    input  logic                    clk,
    input  logic                    reset_i,
    input  logic                    redirect_i,
    input  logic [rv_pkg::XLEN-1:0] target_i,
    input  logic                    stop_fetch_i,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [31:0]             imem_data_i,
    output rv_pkg::fetch_t          fetch_o
);

    logic [rv_pkg::XLEN-1:0] pc_q;
    rv_pkg::fetch_t          fetch_q;

    assign imem_addr_o = pc_q;  // port answers within the cycle

    always_ff @(posedge clk) begin
        if (reset_i) begin
            pc_q <= rv_pkg::PC_RESET;
        end else if (redirect_i) begin
            pc_q <= target_i;  // taken branch from decode
        end else if (!stop_fetch_i) begin
            pc_q <= pc_q + rv_pkg::XLEN'(4);
        end
    end

    // the word fetched in a redirect or stop cycle is dropped
    always_ff @(posedge clk) begin
        fetch_q.pc    <= pc_q;
        fetch_q.inst  <= imem_data_i;
        fetch_q.valid <= ~(redirect_i | stop_fetch_i);
        if (reset_i) begin
            fetch_q.valid <= 1'b0;
        end
    end

    assign fetch_o = fetch_q;

endmodule

// ==== logic/rv_core_top.sv ====
// Top level of the four-stage RV64I integer core
`timescale 1ns/1ps

module rv_core_top (
    input  logic                    clk,
    input  logic                    reset_i,
    output logic [rv_pkg::XLEN-1:0] imem_addr_o,
    input  logic [31:0]             imem_data_i,
    output rv_pkg::retire_t         retire_o,
    output logic                    halt_o
);

    rv_pkg::fetch_t          fetch;
    rv_pkg::id_ex_t          idex;
    rv_pkg::ex_wb_t          exwb;
    rv_pkg::fwd_t            ex_fwd;
    rv_pkg::fwd_t            wb_fwd;
    logic                    redirect;
    logic [rv_pkg::XLEN-1:0] target;
    logic                    stop_fetch;
    logic [rv_pkg::RA_W-1:0] rs1_addr;
    logic [rv_pkg::RA_W-1:0] rs2_addr;
    logic [rv_pkg::XLEN-1:0] rs1_data;
    logic [rv_pkg::XLEN-1:0] rs2_data;

    if_stage u_if_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .redirect_i   (redirect),
        .target_i     (target),
        .stop_fetch_i (stop_fetch),
        .imem_addr_o  (imem_addr_o),
        .imem_data_i  (imem_data_i),
        .fetch_o      (fetch)
    );

    id_stage u_id_stage (
        .clk          (clk),
        .reset_i      (reset_i),
        .fetch_i      (fetch),
        .rs1_addr_o   (rs1_addr),
        .rs2_addr_o   (rs2_addr),
        .rs1_data_i   (rs1_data),
        .rs2_data_i   (rs2_data),
        .ex_fwd_i     (ex_fwd),
        .wb_fwd_i     (wb_fwd),
        .redirect_o   (redirect),
        .target_o     (target),
        .stop_fetch_o (stop_fetch),
        .idex_o       (idex)
    );

    ex_stage u_ex_stage (
        .clk      (clk),
        .reset_i  (reset_i),
        .idex_i   (idex),
        .ex_fwd_o (ex_fwd),
        .exwb_o   (exwb)
    );

    wb_stage u_wb_stage (
        .clk        (clk),
        .reset_i    (reset_i),
        .exwb_i     (exwb),
        .rs1_addr_i (rs1_addr),
        .rs2_addr_i (rs2_addr),
        .rs1_data_o (rs1_data),
        .rs2_data_o (rs2_data),
        .wb_fwd_o   (wb_fwd),
        .retire_o   (retire_o),
        .halt_o     (halt_o)
    );

endmodule

// ==== logic/rv_pkg.sv ====
// Shared definitions of the RV64I core: widths, opcodes, instruction views and stage records
package rv_pkg;

    localparam int unsigned XLEN = 64;
    localparam int unsigned NREG = 32;
    localparam int unsigned RA_W = $clog2(NREG);  // register address width
    localparam logic [XLEN-1:0] PC_RESET = 64'h0000_0000_8000_0000;

    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_BRANCH = 7'b1100011;
    localparam logic [6:0] OPC_SYSTEM = 7'b1110011;
    localparam logic [31:0] EBREAK_WORD = 32'h0010_0073;  // only system op decoded

    typedef struct packed {
        logic [6:0]      funct7;
        logic [RA_W-1:0] rs2;
        logic [RA_W-1:0] rs1;
        logic [2:0]      funct3;
        logic [RA_W-1:0] rd;
        logic [6:0]      opcode;
    } r_fmt_t;

    typedef struct packed {
        logic [11:0]     imm;
        logic [RA_W-1:0] rs1;
        logic [2:0]      funct3;
        logic [RA_W-1:0] rd;
        logic [6:0]      opcode;
    } i_fmt_t;

    typedef struct packed {
        logic [19:0]     imm;  // upper 20 bits of the constant
        logic [RA_W-1:0] rd;
        logic [6:0]      opcode;
    } u_fmt_t;

    typedef struct packed {
        logic            imm_12;
        logic [5:0]      imm_10_5;
        logic [RA_W-1:0] rs2;
        logic [RA_W-1:0] rs1;
        logic [2:0]      funct3;
        logic [3:0]      imm_4_1;
        logic            imm_11;
        logic [6:0]      opcode;
    } b_fmt_t;

    // one instruction word, read through whichever format the opcode calls for
    typedef union packed {
        r_fmt_t r;
        i_fmt_t i;
        u_fmt_t u;
        b_fmt_t b;
    } inst_u;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B  // lui
    } alu_op_e;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        inst_u           inst;
    } fetch_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        alu_op_e         alu_op;
        logic [XLEN-1:0] op_a;
        logic [XLEN-1:0] op_b;
        logic [RA_W-1:0] rd;
        logic            reg_wen;
        logic            ebreak;
    } id_ex_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [RA_W-1:0] rd;
        logic            reg_wen;
        logic [XLEN-1:0] result;
        logic            ebreak;
    } ex_wb_t;

    typedef struct packed {
        logic            valid;
        logic [XLEN-1:0] pc;
        logic [RA_W-1:0] rd;
        logic            reg_wen;
        logic [XLEN-1:0] data;
    } retire_t;

    typedef struct packed {
        logic            valid;  // already qualified with reg_wen
        logic [RA_W-1:0] rd;
        logic [XLEN-1:0] data;
    } fwd_t;

endpackage

// ==== logic/wb_stage.sv ====
// Writeback stage: register file, retire report and halt flag
`timescale 1ns/1ps

module wb_stage (
    input  logic                    clk,
    input  logic                    reset_i,
    input  rv_pkg::ex_wb_t          exwb_i,
    input  logic [rv_pkg::RA_W-1:0] rs1_addr_i,
    input  logic [rv_pkg::RA_W-1:0] rs2_addr_i,
    output logic [rv_pkg::XLEN-1:0] rs1_data_o,
    output logic [rv_pkg::XLEN-1:0] rs2_data_o,
    output rv_pkg::fwd_t            wb_fwd_o,
    output rv_pkg::retire_t         retire_o,
    output logic                    halt_o
);

    logic [rv_pkg::XLEN-1:0] rf [rv_pkg::NREG];
    logic                    wr_en;
    logic                    halt_q;

    assign wr_en = exwb_i.valid && exwb_i.reg_wen && (exwb_i.rd != '0);  // x0 never stored

    always_ff @(posedge clk) begin
        if (wr_en) begin
            rf[exwb_i.rd] <= exwb_i.result;
        end
    end

    assign rs1_data_o = (rs1_addr_i == '0) ? '0 : rf[rs1_addr_i];
    assign rs2_data_o = (rs2_addr_i == '0) ? '0 : rf[rs2_addr_i];

    // same-cycle write is seen by decode through this path
    always_comb begin
        wb_fwd_o.valid = exwb_i.valid & exwb_i.reg_wen;
        wb_fwd_o.rd    = exwb_i.rd;
        wb_fwd_o.data  = exwb_i.result;
    end

    always_comb begin
        retire_o.valid   = exwb_i.valid;
        retire_o.pc      = exwb_i.pc;
        retire_o.rd      = exwb_i.rd;
        retire_o.reg_wen = exwb_i.reg_wen;
        retire_o.data    = exwb_i.result;
    end

    always_ff @(posedge clk) begin
        if (reset_i) begin
            halt_q <= 1'b0;
        end else if (exwb_i.valid && exwb_i.ebreak) begin
            halt_q <= 1'b1;  // rises the cycle after ebreak retires
        end
    end

    assign halt_o = halt_q;

endmodule

// ==== tb.f ====
logic/rv_pkg.sv
logic/if_stage.sv
logic/id_stage.sv
logic/ex_stage.sv
logic/wb_stage.sv
logic/rv_core_top.sv
test/core_chk.sv
test/tb_top.sv

// ==== test/core_chk.sv ====
// Core checker: quiet outputs after reset, sticky halt and no retire once halted
`timescale 1ns/1ps

module core_chk (
    input logic            clk,
    input logic            reset_i,
    input rv_pkg::retire_t retire_i,
    input logic            halt_i
);

    // reset clears every valid and the halt flag
    a_quiet_after_reset: assert property (
        @(posedge clk) reset_i |=> (!retire_i.valid && !halt_i)
    ) else $error("retire or halt active in the cycle after reset");

    a_halt_sticky: assert property (
        @(posedge clk) (halt_i && !reset_i) |=> halt_i  // only reset clears it
    ) else $error("halt dropped without a reset");

    a_no_retire_halted: assert property (
        @(posedge clk) halt_i |-> !retire_i.valid
    ) else $error("instruction retired while the core was halted");

endmodule

bind rv_core_top core_chk u_core_chk (
    .clk      (clk),
    .reset_i  (reset_i),
    .retire_i (retire_o),
    .halt_i   (halt_o)
);

// ==== test/tb_top.sv ====
// Testbench of the RV64I core with random programs, a reference model and a retire compare
`timescale 1ns/1ps

module tb_top;

    localparam int MAX_PROG   = 64;
    localparam int HALT_LIMIT = 600;  // cycles

    typedef rv_pkg::retire_t retire_q_t[$];

    logic                    clk;
    logic                    reset_i;
    logic [rv_pkg::XLEN-1:0] imem_addr;
    logic [31:0]             imem_data;
    rv_pkg::retire_t         retire;
    logic                    halt;

    // 0..6 reg ops, 7..12 imm ops, 13 lui, 14 beq, 15 bne, 16 ebreak
    int              kind_a [MAX_PROG];
    logic [4:0]      rd_a [MAX_PROG];
    logic [4:0]      rs1_a [MAX_PROG];
    logic [4:0]      rs2_a [MAX_PROG];
    int              imm_a [MAX_PROG];  // branch offset in bytes
    logic [31:0]     rom [MAX_PROG];
    int              prog_len;
    logic [31:0]     lcg_state;
    retire_q_t       exp_q;
    rv_pkg::retire_t exp_r;
    string           test_name;
    int              errors;
    int              timeouts;
    int              retired;
    int              exp_count;
    int              checked;
    bit              halt_due;  // last expected retire seen

    rv_core_top dut0 (
        .clk         (clk),
        .reset_i     (reset_i),
        .imem_addr_o (imem_addr),
        .imem_data_i (imem_data),
        .retire_o    (retire),
        .halt_o      (halt)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #5 clk = ~clk;
        end
    end

    function automatic logic [31:0] next_rand();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        return lcg_state >> 8;  // low bits repeat too soon
    endfunction

    function automatic int pick_imm(input int kind);
        if (kind == 11 || kind == 12) begin
            return int'(next_rand() % 64);
        end else if (kind == 13) begin
            return int'(next_rand() % 32'h10_0000) - 524288;
        end
        return int'(next_rand() % 4096) - 2048;
    endfunction

    function automatic logic [31:0] encode(input int kind, input logic [4:0] rd,
                                           input logic [4:0] rs1, input logic [4:0] rs2,
                                           input int imm);
        rv_pkg::inst_u w;
        logic [2:0]    f3;
        logic [12:0]   off;
        off = imm[12:0];
        case (kind)
            0, 1, 7:   f3 = 3'b000;
            2, 8:      f3 = 3'b111;
            3, 9:      f3 = 3'b110;
            4, 10:     f3 = 3'b100;
            5, 11, 15: f3 = 3'b001;
            6, 12:     f3 = 3'b101;
            default:   f3 = 3'b000;
        endcase
        w = '0;
        if (kind <= 6) begin
            w.r.opcode = rv_pkg::OPC_OP;
            w.r.rd     = rd;
            w.r.funct3 = f3;
            w.r.rs1    = rs1;
            w.r.rs2    = rs2;
            w.r.funct7 = (kind == 1) ? 7'b0100000 : 7'b0;
        end else if (kind <= 12) begin
            w.i.opcode = rv_pkg::OPC_OP_IMM;
            w.i.rd     = rd;
            w.i.funct3 = f3;
            w.i.rs1    = rs1;
            w.i.imm    = imm[11:0];
        end else if (kind == 13) begin
            w.u.opcode = rv_pkg::OPC_LUI;
            w.u.rd     = rd;
            w.u.imm    = imm[19:0];
        end else if (kind <= 15) begin
            w.b.opcode   = rv_pkg::OPC_BRANCH;
            w.b.funct3   = f3;
            w.b.rs1      = rs1;
            w.b.rs2      = rs2;
            w.b.imm_12   = off[12];
            w.b.imm_11   = off[11];
            w.b.imm_10_5 = off[10:5];
            w.b.imm_4_1  = off[4:1];
        end else begin
            w = rv_pkg::EBREAK_WORD;
        end
        return w;
    endfunction

    task automatic put_inst(input int idx, input int kind, input logic [4:0] rd,
                            input logic [4:0] rs1, input logic [4:0] rs2, input int imm);
        kind_a[idx] = kind;
        rd_a[idx]   = rd;
        rs1_a[idx]  = rs1;
        rs2_a[idx]  = rs2;
        imm_a[idx]  = imm;
        rom[idx]    = encode(kind, rd, rs1, rs2, imm);
    endtask

    // x1..x7 are written first, then the body, then ebreak
    task automatic build_program(input bit branches, input int body);
        int         idx;
        int         kind;
        int         span;
        logic [4:0] rd;
        logic [4:0] rs1;
        logic [4:0] rs2;
        prog_len = 7 + body + 1;
        for (idx = 0; idx < 7; idx++) begin
            kind = ((next_rand() & 1) != 0) ? 13 : 7;
            put_inst(idx, kind, 5'(idx + 1), 5'd0, 5'd0, pick_imm(kind));
        end
        for (idx = 7; idx < prog_len - 1; idx++) begin
            kind = branches ? int'(next_rand() % 16) : (idx - 7) % 14;
            rd   = 5'(next_rand() % 8);
            rs1  = 5'(next_rand() % 8);
            rs2  = 5'(next_rand() % 8);
            span = prog_len - 1 - idx;  // words left up to the ebreak
            if (kind >= 14 && span < 2) begin
                kind = 0;
            end
            if (kind >= 14) begin
                if (span > 6) begin
                    span = 6;
                end
                put_inst(idx, kind, 5'd0, rs1, rs2, 4 * (2 + int'(next_rand() % 32'(span - 1))));
            end else begin
                put_inst(idx, kind, rd, rs1, rs2, pick_imm(kind));
            end
        end
        put_inst(prog_len - 1, 16, 5'd0, 5'd0, 5'd0, 0);
    endtask

    function automatic logic [31:0] rom_word(input logic [63:0] addr);
        logic [63:0] off;
        off = addr - rv_pkg::PC_RESET;
        if (addr < rv_pkg::PC_RESET || (off >> 2) >= 64'(prog_len)) begin
            return rv_pkg::EBREAK_WORD;  // outside the program
        end
        return rom[off[31:2]];
    endfunction

    // architectural execution of the generated program
    function automatic retire_q_t run_model(input int len);
        logic [63:0]     x [32];
        retire_q_t       q;
        rv_pkg::retire_t r;
        logic [63:0]     a;
        logic [63:0]     b;
        logic [63:0]     res;
        int              i;
        int              k;
        int              steps;
        for (k = 0; k < 32; k++) begin
            x[k] = '0;
        end
        i     = 0;
        steps = 0;
        while (i < len && steps < 4 * MAX_PROG) begin
            a = x[rs1_a[i]];
            b = (kind_a[i] >= 7 && kind_a[i] <= 13) ? longint'(imm_a[i]) : x[rs2_a[i]];
            case (kind_a[i])
                0, 7:    res = a + b;
                1:       res = a - b;
                2, 8:    res = a & b;
                3, 9:    res = a | b;
                4, 10:   res = a ^ b;
                5, 11:   res = a << b[5:0];
                6, 12:   res = a >> b[5:0];
                13:      res = longint'(imm_a[i]) << 12;
                default: res = '0;
            endcase
            r.valid = 1'b1;
            r.pc    = rv_pkg::PC_RESET + 64'(4 * i);
            if (kind_a[i] >= 14) begin
                r.rd      = '0;  // branch and ebreak write nothing
                r.reg_wen = 1'b0;
                r.data    = '0;
            end else begin
                r.rd      = rd_a[i];
                r.reg_wen = 1'b1;
                r.data    = res;
                if (rd_a[i] != 0) begin
                    x[rd_a[i]] = res;
                end
            end
            q.push_back(r);
            if (kind_a[i] == 16) begin
                i = len;
            end else if ((kind_a[i] == 14 && a == b) || (kind_a[i] == 15 && a != b)) begin
                i = i + imm_a[i] / 4;
            end else begin
                i++;
            end
            steps++;
        end
        return q;
    endfunction

    function automatic string fmt_retire(input rv_pkg::retire_t r);
        return $sformatf("pc=%h rd=%0d wen=%b data=%h", r.pc, r.rd, r.reg_wen, r.data);
    endfunction

    task automatic check_retire(input string name, input rv_pkg::retire_t exp,
                                input rv_pkg::retire_t act);
        checked++;
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected %s, actual %s", name, fmt_retire(exp), fmt_retire(act));
        end
    endtask

    task automatic check_halt(input string name, input logic exp, input logic act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected halt_o=%b, actual %b", name, exp, act);
        end
    endtask

    task automatic check_addr(input string name, input logic [rv_pkg::XLEN-1:0] exp,
                              input logic [rv_pkg::XLEN-1:0] act);
        if (act !== exp) begin
            errors++;
            $display("Error %s: expected imem_addr_o=%h, actual %h", name, exp, act);
        end
    endtask

    task automatic check_count(input string name, input int exp, input int act);
        if (act != exp) begin
            errors++;
            $display("Error %s: expected %0d retires, actual %0d", name, exp, act);
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #1;
    endtask

    always @(posedge clk) begin
        #1 imem_data = rom_word(imem_addr);  // port answers from the current pc
    end

    always @(negedge clk) begin
        if (!reset_i) begin
            check_halt(test_name, halt_due, halt);
            if (retire.valid) begin
                if (exp_q.size() == 0) begin
                    errors++;
                    $display("%s: retire at pc %h after the program had ended",
                             test_name, retire.pc);
                end else begin
                    exp_r = exp_q.pop_front();
                    check_retire(test_name, exp_r, retire);
                    if (exp_q.size() == 0) begin
                        halt_due = 1'b1;
                    end
                end
                retired++;
            end
        end
    end

    task automatic start_program();
        reset_i  = 1'b1;
        halt_due = 1'b0;
        repeat (3) next_cycle();
        exp_q     = run_model(prog_len);
        exp_count = exp_q.size();
        retired   = 0;
        reset_i   = 1'b0;
        check_addr(test_name, rv_pkg::PC_RESET, imem_addr);  // first fetch address
    endtask

    task automatic wait_retires(input int n, input int limit);
        int cycles;
        cycles = 0;
        while (retired < n && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (retired < n) begin
            timeouts++;
            $display("%s: only %0d of %0d retires seen within %0d cycles",
                     test_name, retired, n, limit);
        end
    endtask

    task automatic wait_halt(input int limit);
        int cycles;
        cycles = 0;
        while (halt !== 1'b1 && cycles < limit) begin
            next_cycle();
            cycles++;
        end
        if (halt !== 1'b1) begin
            timeouts++;
            $display("%s: core did not halt within %0d cycles", test_name, limit);
        end
    endtask

    task automatic finish_program();
        wait_halt(HALT_LIMIT);
        repeat (6) next_cycle();  // halt holds and nothing retires
        check_count(test_name, exp_count, retired);
    endtask

    initial begin
        reset_i   = 1'b1;
        imem_data = rv_pkg::EBREAK_WORD;
        lcg_state = 32'd36;
        prog_len  = 0;
        errors    = 0;
        timeouts  = 0;
        retired   = 0;
        exp_count = 0;
        checked   = 0;
        halt_due  = 1'b0;
        test_name = "alu_ops";
        build_program(1'b0, 28);
        start_program();
        finish_program();
        test_name = "fwd_branch_a";
        build_program(1'b1, 48);
        start_program();
        finish_program();
        test_name = "fwd_branch_b";
        build_program(1'b1, 48);
        start_program();
        finish_program();
        test_name = "reset_restart";
        build_program(1'b1, 40);
        start_program();
        wait_retires(12, 100);
        start_program();  // reset lands in the middle of the program
        finish_program();
        $display("Closing report: %0d errors, %0d timeouts, %0d retires compared",
                 errors, timeouts, checked);
        if (errors == 0 && timeouts == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule
